//--- Bender.yml
package:
  name: edge_filter

dependencies: {}

sources:
  # packages first, then the datapath and control, then the top level
  - files:
      - rtl/video_pkg.sv
      - rtl/filter_pkg.sv
      - rtl/line_shift_ram.sv
      - rtl/window_3x3.sv
      - rtl/sobel_core.sv
      - rtl/result_fifo.sv
      - rtl/stream_ctrl.sv
      - rtl/edge_filter_top.sv
  - target: test
    files:
      - verif/tb_edge_filter.sv

//--- rtl/edge_filter_top.sv
`timescale 1ns/1ps

module edge_filter_top
    import video_pkg::*;
    import filter_pkg::*;
#(
    parameter int IMG_WIDTH  = 1280,
    parameter int IMG_HEIGHT = 720,
    parameter int RES_DEPTH  = 4,                  // result FIFO slots
    parameter int DS_CREDITS = 4                   // credits toward downstream
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  pix_beat_t        in_beat,
    input  filter_cfg_t      cfg,                  // sampled on sof
    // one pulse per result leaving the FIFO
    // upstream spends a credit only on beats that produce a result,
    // border beats of the first two rows and columns are free
    output logic             in_credit,
    output logic             out_valid,
    output logic [PIX_W-1:0] out_data,
    output logic             out_eof,              // last result of frame
    input  logic             ds_credit
);

    logic             win_en;
    logic [PIX_W-1:0] pix;
    window_t          win;
    logic             core_valid, core_last;
    filter_cfg_t      cfg_q;
    logic             res_valid, res_last;
    logic [PIX_W-1:0] res_data;
    logic             fifo_empty, pop;

    // --------------------
    // control
    // --------------------
    stream_ctrl #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .DS_CREDITS (DS_CREDITS)
    ) i_stream_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .cfg        (cfg),
        .ds_credit  (ds_credit),
        .fifo_empty (fifo_empty),
        .win_en     (win_en),
        .pix        (pix),
        .core_valid (core_valid),
        .core_last  (core_last),
        .cfg_q      (cfg_q),
        .pop        (pop),
        .in_credit  (in_credit),
        .out_valid  (out_valid)
    );

    // --------------------
    // datapath
    // --------------------
    window_3x3 #(
        .IMG_WIDTH (IMG_WIDTH)
    ) i_window_3x3 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (win_en),
        .pix   (pix),
        .win   (win)
    );

    sobel_core i_sobel_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_valid (core_valid),
        .core_last  (core_last),
        .cfg        (cfg_q),
        .win        (win),
        .res_valid  (res_valid),
        .res_last   (res_last),
        .res_data   (res_data)
    );

    result_fifo #(
        .DEPTH (RES_DEPTH)
    ) i_result_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (res_valid),
        .push_last (res_last),
        .push_data (res_data),
        .pop       (pop),
        .empty     (fifo_empty),
        .head_data (out_data),                     // valid with out_valid
        .head_last (out_eof)
    );

endmodule

//--- rtl/filter_pkg.sv
package filter_pkg;

    // --------------------
    // filter operations
    // --------------------
    typedef enum logic [1:0] {
        op_pass   = 2'd0,                          // centre pixel unchanged
        op_sobel  = 2'd1,                          // saturated |gx|+|gy|
        op_binary = 2'd2                           // magnitude vs threshold
    } filter_op_e;

    // --------------------
    // per-frame config
    // --------------------
    // sampled on the sof beat, held for the whole frame
    typedef struct packed {
        filter_op_e op;                            // selected operation
        logic [7:0] threshold;                     // edge threshold, binary only
    } filter_cfg_t;

endpackage

//--- rtl/line_shift_ram.sv
`timescale 1ns/1ps

module line_shift_ram
    import video_pkg::*;
#(
    parameter int LINE_LENGTH = 1280               // pixels per line
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,                   // advance on input beat
    input  logic [PIX_W-1:0] d,                    // sample entering the line
    output logic [PIX_W-1:0] q                     // sample one line older
);

    localparam int PW = (LINE_LENGTH > 1) ? $clog2(LINE_LENGTH) : 1;

    logic [PIX_W-1:0] mem [LINE_LENGTH];           // circular line buffer
    logic [PW-1:0]    ptr;                         // shared read/write slot

    // read before write on the same slot
    // so q is the value stored LINE_LENGTH beats ago
    assign q = mem[ptr];

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk) begin
        if (en) begin
            mem[ptr] <= d;                         // overwrite oldest sample
        end
    end

    // --------------------
    // pointer
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (en) begin
            if (ptr == PW'(LINE_LENGTH - 1)) begin
                ptr <= '0;                         // wrap at end of line
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

//--- rtl/result_fifo.sv
`timescale 1ns/1ps

module result_fifo
    import video_pkg::*;
#(
    parameter int DEPTH = 4                        // result slots
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic             push_last,            // end-of-frame marker
    input  logic [PIX_W-1:0] push_data,
    input  logic             pop,
    output logic             empty,
    output logic [PIX_W-1:0] head_data,            // oldest entry
    output logic             head_last
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [PIX_W:0]  mem [DEPTH];                  // {last, data}
    logic [AW-1:0]   wr_ptr, rd_ptr;
    logic [CW-1:0]   count;
    logic            do_pop;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty     = (count == '0);              // from registered count
    assign do_pop    = pop & ~empty;
    assign head_data = mem[rd_ptr][PIX_W-1:0];
    assign head_last = mem[rd_ptr][PIX_W];

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {push_last, push_data}; // room guaranteed by credits
        end
    end

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)   wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // idle or push with pop
            endcase
        end
    end

endmodule

//--- rtl/sobel_core.sv
`timescale 1ns/1ps

module sobel_core
    import video_pkg::*;
    import filter_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             core_valid,           // interior window present
    input  logic             core_last,            // last window of frame
    input  filter_cfg_t      cfg,                  // frame config, latched
    input  window_t          win,                  // 3x3 neighbourhood
    output logic             res_valid,
    output logic             res_last,
    output logic [PIX_W-1:0] res_data
);

    // 1-2-1 weighted sum of three pixels, max 1020
    function automatic logic [PIX_W+1:0] weighted_sum(
        input logic [PIX_W-1:0] a,
        input logic [PIX_W-1:0] b,
        input logic [PIX_W-1:0] c
    );
        return {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
    endfunction

    logic signed [PIX_W+2:0] gx_c, gy_c;           // +-1020, 11 bits signed
    logic signed [PIX_W+2:0] s1_gx, s1_gy;
    logic [PIX_W-1:0]        s1_p22;               // centre for pass mode
    filter_cfg_t             s1_cfg;
    logic                    s1_valid, s1_last;
    logic [PIX_W+1:0]        abs_gx, abs_gy;
    logic [PIX_W+2:0]        mag_sum;              // up to 2040
    logic [PIX_W-1:0]        mag_sat;
    logic [PIX_W-1:0]        result_c;

    // --------------------
    // stage 1 gradients
    // --------------------
    assign gx_c = $signed({1'b0, weighted_sum(win.p13, win.p23, win.p33)})
                - $signed({1'b0, weighted_sum(win.p11, win.p21, win.p31)}); // right - left
    assign gy_c = $signed({1'b0, weighted_sum(win.p31, win.p32, win.p33)})
                - $signed({1'b0, weighted_sum(win.p11, win.p12, win.p13)}); // bottom - top

    always_ff @(posedge clk) begin
        s1_gx  <= gx_c;
        s1_gy  <= gy_c;
        s1_p22 <= win.p22;
        s1_cfg <= cfg;                             // travels with its window
    end

    // --------------------
    // stage 2 magnitude
    // --------------------
    assign abs_gx  = s1_gx[PIX_W+2] ? (PIX_W+2)'(-s1_gx) : (PIX_W+2)'(s1_gx);
    assign abs_gy  = s1_gy[PIX_W+2] ? (PIX_W+2)'(-s1_gy) : (PIX_W+2)'(s1_gy);
    assign mag_sum = {1'b0, abs_gx} + {1'b0, abs_gy};
    assign mag_sat = (|mag_sum[PIX_W+2:PIX_W]) ? {PIX_W{1'b1}} : mag_sum[PIX_W-1:0];

    always_comb begin
        case (s1_cfg.op)
            op_pass:   result_c = s1_p22;
            op_sobel:  result_c = mag_sat;
            op_binary: result_c = (mag_sat >= s1_cfg.threshold) ? {PIX_W{1'b1}} : '0;
            default:   result_c = s1_p22;          // spare encoding acts as pass
        endcase
    end

    always_ff @(posedge clk) begin
        res_data <= result_c;
    end

    // valid pipe, two cycles from core_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            res_valid <= 1'b0;
            res_last  <= 1'b0;
        end else begin
            s1_valid  <= core_valid;
            s1_last   <= core_valid & core_last;
            res_valid <= s1_valid;
            res_last  <= s1_valid & s1_last;
        end
    end

endmodule

//--- rtl/stream_ctrl.sv
`timescale 1ns/1ps

module stream_ctrl
    import video_pkg::*;
    import filter_pkg::*;
#(
    parameter int IMG_WIDTH  = 1280,
    parameter int IMG_HEIGHT = 720,
    parameter int DS_CREDITS = 4                   // initial downstream credits
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  pix_beat_t        in_beat,
    input  filter_cfg_t      cfg,
    input  logic             ds_credit,            // one slot freed downstream
    input  logic             fifo_empty,
    output logic             win_en,
    output logic [PIX_W-1:0] pix,
    output logic             core_valid,
    output logic             core_last,
    output filter_cfg_t      cfg_q,
    output logic             pop,
    output logic             in_credit,
    output logic             out_valid
);

    localparam int CW = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
    localparam int RW = (IMG_HEIGHT > 1) ? $clog2(IMG_HEIGHT) : 1;
    localparam int DW = $clog2(DS_CREDITS + 1);

    typedef enum logic {
        st_idle,                                   // waiting for sof
        st_frame                                   // inside a frame
    } frame_state_e;

    frame_state_e  state_q;
    logic [CW-1:0] col_q, cur_col;                 // position of next / this beat
    logic [RW-1:0] row_q, cur_row;
    logic          beat_in_frame;
    logic          interior;                       // window centre off the border
    logic          final_beat;
    logic [DW-1:0] ds_cnt_q;
    logic          pop_w;

    // window path follows every beat
    assign win_en = in_valid;
    assign pix    = in_beat.data;

    // --------------------
    // raster position
    // --------------------
    assign beat_in_frame = in_valid & (in_beat.sof | (state_q == st_frame));
    assign cur_col       = in_beat.sof ? '0 : col_q;
    assign cur_row       = in_beat.sof ? '0 : row_q;
    assign interior      = beat_in_frame & (cur_col >= 2) & (cur_row >= 2);
    assign final_beat    = beat_in_frame & in_beat.eol & (cur_row == RW'(IMG_HEIGHT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            col_q   <= '0;
            row_q   <= '0;
            cfg_q   <= '{op: op_pass, threshold: '0};
        end else if (beat_in_frame) begin
            state_q <= final_beat ? st_idle : st_frame;
            if (in_beat.sof) cfg_q <= cfg;         // config fixed for the frame
            if (in_beat.eol) begin
                col_q <= '0;                       // wrap to next line
                row_q <= cur_row + 1'b1;
            end else begin
                col_q <= cur_col + 1'b1;
                row_q <= cur_row;
            end
        end
    end

    // window ready one cycle after the qualifying beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_valid <= 1'b0;
            core_last  <= 1'b0;
        end else begin
            core_valid <= interior;
            core_last  <= interior & final_beat;
        end
    end

    // --------------------
    // credit handling
    // --------------------
    assign pop_w     = ~fifo_empty & (ds_cnt_q != '0);
    assign pop       = pop_w;
    assign out_valid = pop_w;                      // head shown while popping
    assign in_credit = pop_w;                      // slot freed for upstream

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_cnt_q <= DW'(DS_CREDITS);
        end else begin
            case ({pop_w, ds_credit})
                2'b10:   ds_cnt_q <= ds_cnt_q - 1'b1;  // result sent
                2'b01:   ds_cnt_q <= ds_cnt_q + 1'b1;  // credit back
                default: ds_cnt_q <= ds_cnt_q;
            endcase
        end
    end

endmodule

//--- rtl/video_pkg.sv
package video_pkg;

    // --------------------
    // pixel format
    // --------------------
    localparam int PIX_W = 8;                      // grayscale depth

    // one input beat from upstream
    typedef struct packed {
        logic             sof;                     // first pixel of frame
        logic             eol;                     // last pixel of line
        logic [PIX_W-1:0] data;                    // luma sample
    } pix_beat_t;

    // --------------------
    // 3x3 neighbourhood
    // --------------------
    // row 1 is the oldest line, column 1 the oldest pixel
    typedef struct packed {
        logic [PIX_W-1:0] p11;                     // top left
        logic [PIX_W-1:0] p12;                     // top centre
        logic [PIX_W-1:0] p13;                     // top right
        logic [PIX_W-1:0] p21;                     // mid left
        logic [PIX_W-1:0] p22;                     // centre pixel
        logic [PIX_W-1:0] p23;                     // mid right
        logic [PIX_W-1:0] p31;                     // bottom left
        logic [PIX_W-1:0] p32;                     // bottom centre
        logic [PIX_W-1:0] p33;                     // bottom right, newest
    } window_t;

endpackage

//--- rtl/window_3x3.sv
`timescale 1ns/1ps

module window_3x3
    import video_pkg::*;
#(
    parameter int IMG_WIDTH = 1280                 // line length of the frame
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,                   // one shift per input beat
    input  logic [PIX_W-1:0] pix,                  // incoming pixel, row 3
    output window_t          win                   // registered neighbourhood
);

    logic [PIX_W-1:0] row2_q;                      // same column, previous line
    logic [PIX_W-1:0] row1_q;                      // same column, two lines back
    window_t          win_q;

    // --------------------
    // line delays
    // --------------------
    // pixel feeds row 2 delay, row 2 output feeds row 1 delay
    line_shift_ram #(
        .LINE_LENGTH (IMG_WIDTH)
    ) i_line_row2 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .d     (pix),                              // current line in
        .q     (row2_q)                            // previous line out
    );

    line_shift_ram #(
        .LINE_LENGTH (IMG_WIDTH)
    ) i_line_row1 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .d     (row2_q),                           // cascade from row 2
        .q     (row1_q)                            // oldest line out
    );

    // --------------------
    // window shift
    // --------------------
    // all rows move left, new column enters at column 3
    always_ff @(posedge clk) begin
        if (en) begin
            win_q.p11 <= win_q.p12;
            win_q.p12 <= win_q.p13;
            win_q.p13 <= row1_q;                   // top row from oldest line
            win_q.p21 <= win_q.p22;
            win_q.p22 <= win_q.p23;
            win_q.p23 <= row2_q;                   // middle row
            win_q.p31 <= win_q.p32;
            win_q.p32 <= win_q.p33;
            win_q.p33 <= pix;                      // bottom row, live pixel
        end
    end

    // window valid one cycle after the beat that built it
    assign win = win_q;

endmodule

//--- verif/sobel_golden.hex
// per frame: cfg word {op[1:0], threshold[7:0]}, 48 pixels in raster order (8 per line),
// then 24 expected results in raster order of the interior centres (6 per line)
// frame 1, op_sobel
100
00 0A 1E 1E 3C 5A 5A 50
05 0F 23 23 41 5F 5F 55
05 0F 23 23 41 5F 5F 55
14 1E 32 32 50 6E 6E 64
28 32 46 46 64 82 82 78
28 32 46 46 64 82 82 78
// frame 1 expected magnitudes
8C 64 8C FF 8C 3C
B4 8C B4 FF B4 64
FF DC FF FF FF B4
C8 A0 C8 FF C8 78
// frame 2, op_binary, threshold 0x40
240
E6 E6 E1 82 46 46 56 46
E6 E6 E1 82 46 46 56 46
DC DC D7 78 3C 3C 4C 3C
C8 C8 C3 64 28 28 38 28
C8 C8 C3 64 28 28 38 28
C8 C8 C3 64 28 28 38 28
// frame 2 expected edge map
00 FF FF FF FF 00
FF FF FF FF FF FF
FF FF FF FF FF FF
00 FF FF FF FF 00

//--- verif/tb_edge_filter.sv
`timescale 1ns/1ps

module tb_edge_filter
    import video_pkg::*;
    import filter_pkg::*;
();

    localparam int IMG_W        = 8;
    localparam int IMG_H        = 6;
    localparam int RES_DEPTH    = 4;
    localparam int DS_CREDITS   = 4;
    localparam int FRAME_WORDS  = 1 + IMG_W*IMG_H + (IMG_W-2)*(IMG_H-2); // cfg, pixels, results
    localparam int RES_PER_FRM  = (IMG_W-2)*(IMG_H-2);
    localparam int NUM_FRAMES   = 3;                         // sobel, binary, pass
    localparam int NUM_RESULTS  = NUM_FRAMES*RES_PER_FRM;
    localparam int TOTAL_BEATS  = NUM_FRAMES*IMG_W*IMG_H;
    localparam int TIMEOUT_CYC  = 20*TOTAL_BEATS;
    localparam int F1_BASE      = 0;
    localparam int F2_BASE      = FRAME_WORDS;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    pix_beat_t   in_beat;
    filter_cfg_t cfg;
    logic        in_credit;
    logic        out_valid;
    logic [7:0]  out_data;
    logic        out_eof;
    logic        ds_credit;

    logic [9:0]  golden [2*FRAME_WORDS];                     // two frames from file
    logic [7:0]  exp_data [NUM_RESULTS];
    logic        exp_last [NUM_RESULTS];
    filter_cfg_t pass_cfg;

    int credits_granted  = 0;                                // in_credit pulses seen
    int credits_spent    = 0;                                // interior beats sent
    int credits_returned = 0;                                // ds_credit pulses sent
    int results_rcvd     = 0;
    int ds_model         = DS_CREDITS;
    int data_errors      = 0;
    int flow_errors      = 0;
    int count_errors     = 0;
    int cycles           = 0;
    int unsigned rnd;

    always #20 clk = ~clk;                                   // 40 ns period

    edge_filter_top #(
        .IMG_WIDTH  (IMG_W),
        .IMG_HEIGHT (IMG_H),
        .RES_DEPTH  (RES_DEPTH),
        .DS_CREDITS (DS_CREDITS)
    ) i_edge_filter_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .cfg       (cfg),
        .in_credit (in_credit),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_eof   (out_eof),
        .ds_credit (ds_credit)
    );

    // --------------------
    // upstream driver
    // --------------------
    // border beats go free and interior beats cost a credit
    task automatic send_frame(input int base, input filter_cfg_t fcfg);
        int   r;
        int   c;
        logic interior;
        logic sof_beat;
        for (r = 0; r < IMG_H; r++) begin
            for (c = 0; c < IMG_W; c++) begin
                interior = (r >= 2) && (c >= 2);
                sof_beat = (r == 0) && (c == 0);
                while (interior && (RES_DEPTH + credits_granted - credits_spent) <= 0) begin
                    in_valid = 1'b0;                         // stall for a credit
                    @(posedge clk);
                    #2;
                end
                in_valid = 1'b1;
                in_beat  = '{sof: sof_beat, eol: (c == IMG_W-1),
                             data: golden[base + 1 + r*IMG_W + c][7:0]};
                cfg      = sof_beat ? fcfg : filter_cfg_t'(~fcfg); // only sof carries the config
                if (interior) credits_spent++;
                @(posedge clk);
                #2;
            end
        end
        in_valid = 1'b0;
    endtask

    // golden results for frames 1 and 2 plus frame 1 centres for pass mode
    task automatic build_expected();
        int k;
        int r;
        int c;
        for (k = 0; k < RES_PER_FRM; k++) begin
            exp_data[k]               = golden[F1_BASE + 1 + IMG_W*IMG_H + k][7:0];
            exp_data[RES_PER_FRM + k] = golden[F2_BASE + 1 + IMG_W*IMG_H + k][7:0];
        end
        k = 2*RES_PER_FRM;
        for (r = 1; r < IMG_H-1; r++) begin
            for (c = 1; c < IMG_W-1; c++) begin
                exp_data[k] = golden[F1_BASE + 1 + r*IMG_W + c][7:0]; // centre pixel
                k++;
            end
        end
        for (k = 0; k < NUM_RESULTS; k++) begin
            exp_last[k] = ((k % RES_PER_FRM) == RES_PER_FRM-1);
        end
    endtask

    // --------------------
    // output monitor
    // --------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_credit) credits_granted++;
            if (out_valid) begin
                if (ds_model <= 0) begin
                    flow_errors++;
                    $display("out_valid raised with no downstream credit left, result %0d",
                             results_rcvd);
                end
                ds_model--;
                if (results_rcvd >= NUM_RESULTS) begin
                    count_errors++;
                    $display("extra result beyond the expected %0d", NUM_RESULTS);
                end else begin
                    if (out_data !== exp_data[results_rcvd]) begin
                        data_errors++;
                        $display("[ERROR] out_data result %0d: expected 0x%02h, got 0x%02h",
                                 results_rcvd, exp_data[results_rcvd], out_data);
                    end
                    if (out_eof !== exp_last[results_rcvd]) begin
                        data_errors++;
                        $display("[ERROR] out_eof result %0d: expected 0x%01h, got 0x%01h",
                                 results_rcvd, exp_last[results_rcvd], out_eof);
                    end
                end
                results_rcvd++;
            end
            if (ds_credit) ds_model++;                       // slot back downstream
        end
    end

    // downstream consumer returns credits at random times
    initial begin
        ds_credit = 1'b0;
        rnd = $urandom(32'hee1b_92a0);                       // one seed for the run
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #2;
            rnd = $urandom;
            if ((results_rcvd > credits_returned) && ((rnd % 3) == 0)) begin
                ds_credit = 1'b1;
                credits_returned++;
            end else begin
                ds_credit = 1'b0;
            end
        end
    end

    // watchdog
    initial begin
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d results seen, stream deadlocked",
                 cycles, results_rcvd, NUM_RESULTS);
        $display("FAIL: see errors above");
        $finish;
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        cfg      = '0;
        pass_cfg = '{op: op_pass, threshold: 8'h00};
        $readmemh("verif/sobel_golden.hex", golden);
        build_expected();
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        send_frame(F1_BASE, filter_cfg_t'(golden[F1_BASE]));  // sobel magnitude
        send_frame(F2_BASE, filter_cfg_t'(golden[F2_BASE]));  // binary at 0x40
        send_frame(F1_BASE, pass_cfg);                        // centre passthrough
        while (results_rcvd < NUM_RESULTS) @(posedge clk);
        repeat (10) @(posedge clk);                           // catch stray results
        if (results_rcvd != NUM_RESULTS) begin
            count_errors++;
            $display("result count wrong: expected %0d, got %0d", NUM_RESULTS, results_rcvd);
        end
        if (credits_granted != results_rcvd) begin
            count_errors++;
            $display("in_credit pulses (%0d) do not match results (%0d)",
                     credits_granted, results_rcvd);
        end
        $display("errors: data %0d, flow %0d, count %0d", data_errors, flow_errors, count_errors);
        if (data_errors + flow_errors + count_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/video_pkg.sv
rtl/filter_pkg.sv
rtl/line_shift_ram.sv
rtl/window_3x3.sv
rtl/sobel_core.sv
rtl/result_fifo.sv
rtl/stream_ctrl.sv
rtl/edge_filter_top.sv
verif/tb_edge_filter.sv
